// ==== Bender.yml ====
package:
  name: mem_sys

export_include_dirs:
  - common

sources:
  - common/mem_sys_pkg.sv
  - bram/boot_ram.sv
  - bram/bram_ctrl.sv
  - logic/addr_router.sv
  - logic/req_port.sv
  - logic/mem_sys_top.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_mem_sys.sv

// ==== bram/boot_ram.sv ====
// inferred boot RAM line array with byte write enables and a registered read index
`include "mem_sys_macros.svh"

`default_nettype none

module boot_ram (
   input  wire logic                    mig_clk,
   input  wire logic                    en_i,
   input  wire logic [`BRAM_IDX_W-1:0]  idx_i,
   input  wire logic [`MEM_STRB_W-1:0]  we_i,
   input  wire logic [`MEM_DATA_W-1:0]  wdata_i,
   output logic      [`MEM_DATA_W-1:0]  rdata_o
);

   logic [`MEM_DATA_W-1:0]  ram_q [0:`BRAM_LINES-1];
   logic [`BRAM_IDX_W-1:0]  idx_dly_q;

   always_ff @(posedge mig_clk) begin
      if (en_i) begin
         idx_dly_q <= idx_i;
         for (int b = 0; b < `MEM_STRB_W; b++) begin
            if (we_i[b]) begin
               ram_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
   end

   // read follows the registered index
   assign rdata_o = ram_q[idx_dly_q];

endmodule

`default_nettype wire

// ==== bram/bram_ctrl.sv ====
// boot RAM controller, turns a routed request into enable, line index and strobes
`include "mem_sys_macros.svh"

`default_nettype none

module bram_ctrl
   import mem_sys_pkg::*;
(
   input  wire logic       mig_clk,
   input  wire logic       rst_i,
   input  wire logic       start_i,
   input  wire mem_req_t   req_i,
   output logic            done_o,
   output mem_resp_t       resp_o
);

   ctrl_state_e              state_q;
   logic                     en_q;
   logic                     done_q;
   mem_op_e                  op_q;
   logic [`BRAM_IDX_W-1:0]   idx_q;
   logic [`MEM_STRB_W-1:0]   we_q;
   logic [`MEM_DATA_W-1:0]   wdata_q;
   logic [`MEM_DATA_W-1:0]   rdata;

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         state_q <= CTRL_IDLE;
         en_q    <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         en_q   <= start_i;   // one enabled RAM cycle per request
         done_q <= 1'b0;
         unique case (state_q)
            CTRL_IDLE: begin
               if (start_i) begin
                  if (req_i.op == MEM_WRITE) begin
                     done_q <= 1'b1;
                  end else begin
                     state_q <= CTRL_READ_WAIT;
                  end
               end
            end
            CTRL_READ_WAIT: begin
               // data is out of the RAM register when done shows
               done_q  <= 1'b1;
               state_q <= CTRL_IDLE;
            end
            default: state_q <= CTRL_IDLE;
         endcase
      end
   end

   always_ff @(posedge mig_clk) begin
      if (start_i) begin
         op_q    <= req_i.op;
         idx_q   <= req_i.addr[`BRAM_IDX_W+`BRAM_LINE_OFFSET-1:`BRAM_LINE_OFFSET];
         we_q    <= (req_i.op == MEM_WRITE) ? req_i.strb : '0;   // no writes on a read
         wdata_q <= req_i.wdata;
      end
   end

   boot_ram u_boot_ram (
      .mig_clk ( mig_clk ),
      .en_i    ( en_q    ),
      .idx_i   ( idx_q   ),
      .we_i    ( we_q    ),
      .wdata_i ( wdata_q ),
      .rdata_o ( rdata   )
   );

   assign done_o = done_q;
   assign resp_o = mem_resp_t'{rdata: (op_q == MEM_READ) ? rdata : '0, err: 1'b0};

endmodule

`default_nettype wire

// ==== common/mem_sys_macros.svh ====
// widths, boot RAM geometry and address map, included by the package and the RTL
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// master port
`define MEM_ADDR_W        32
`define MEM_DATA_W        64
`define MEM_STRB_W        (`MEM_DATA_W / 8)

// boot RAM geometry
`define BRAM_LINES        256
`define BRAM_LINE_OFFSET  3     // byte within a 64-bit line
`define BRAM_IDX_W        8     // log2 of BRAM_LINES

// address map, mask marks the ignored low bits
`define BRAM_BASE         (32'h0000_0000)
`define BRAM_MASK         (32'h0000_07ff)

`endif

// ==== common/mem_sys_pkg.sv ====
// request/response types and FSM states shared by the memory subsystem and its testbench
`include "mem_sys_macros.svh"

`default_nettype none

package mem_sys_pkg;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   // one line access from the master
   typedef struct packed {
      mem_op_e                 op;
      logic [`MEM_ADDR_W-1:0]  addr;
      logic [`MEM_DATA_W-1:0]  wdata;
      logic [`MEM_STRB_W-1:0]  strb;
   } mem_req_t;

   typedef struct packed {
      logic [`MEM_DATA_W-1:0]  rdata;
      logic                    err;    // decode error
   } mem_resp_t;

   // front end handshake
   typedef enum logic [1:0] {
      PORT_IDLE,
      PORT_BUSY,
      PORT_ACK
   } port_state_e;

   // RAM controller
   typedef enum logic {
      CTRL_IDLE,
      CTRL_READ_WAIT
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/addr_router.sv ====
// base/mask address decode, forwards hits to the boot RAM and answers misses with an error
`include "mem_sys_macros.svh"

`default_nettype none

module addr_router
   import mem_sys_pkg::*;
(
   input  wire logic       mig_clk,
   input  wire logic       rst_i,
   input  wire logic       start_i,
   input  wire mem_req_t   req_i,
   output logic            done_o,
   output mem_resp_t       resp_o
);

   logic       hit;
   logic       miss_done;
   logic       bram_start;
   logic       bram_done;
   mem_resp_t  bram_resp;

   // compare only the bits above the region mask
   assign hit = (req_i.addr & ~`BRAM_MASK) == (`BRAM_BASE & ~`BRAM_MASK);

   assign bram_start = start_i & hit;
   assign miss_done  = start_i & ~hit;   // same cycle answer

   bram_ctrl u_bram_ctrl (
      .mig_clk ( mig_clk    ),
      .rst_i   ( rst_i      ),
      .start_i ( bram_start ),
      .req_i   ( req_i      ),
      .done_o  ( bram_done  ),
      .resp_o  ( bram_resp  )
   );

   // req_i is held by the front end, so hit is stable until done
   assign done_o = bram_done | miss_done;
   assign resp_o = hit ? bram_resp : mem_resp_t'{rdata: '0, err: 1'b1};

endmodule

`default_nettype wire

// ==== logic/mem_sys_top.sv ====
// memory subsystem top, a four-phase req/ack master port in front of the decoded boot RAM
`default_nettype none

module mem_sys_top
   import mem_sys_pkg::*;
(
   input  wire logic       mig_clk,
   input  wire logic       rst_i,

   // master port
   input  wire logic       req_i,
   input  wire mem_req_t   req_data_i,
   output logic            ack_o,
   output mem_resp_t       resp_o
);

   logic       start;
   mem_req_t   req;
   logic       done;
   mem_resp_t  resp;

   req_port u_req_port (
      .mig_clk    ( mig_clk    ),
      .rst_i      ( rst_i      ),
      .req_i      ( req_i      ),
      .req_data_i ( req_data_i ),
      .ack_o      ( ack_o      ),
      .resp_o     ( resp_o     ),
      .start_o    ( start      ),
      .req_o      ( req        ),
      .done_i     ( done       ),
      .resp_i     ( resp       )
   );

   // decoder owns the RAM block
   addr_router u_addr_router (
      .mig_clk    ( mig_clk    ),
      .rst_i      ( rst_i      ),
      .start_i    ( start      ),
      .req_i      ( req        ),
      .done_o     ( done       ),
      .resp_o     ( resp       )
   );

endmodule

`default_nettype wire

// ==== logic/req_port.sv ====
// four-phase req/ack front end, captures one request and holds its response until req drops
`default_nettype none

module req_port
   import mem_sys_pkg::*;
(
   input  wire logic       mig_clk,
   input  wire logic       rst_i,

   // master side
   input  wire logic       req_i,
   input  wire mem_req_t   req_data_i,
   output logic            ack_o,
   output mem_resp_t       resp_o,

   // toward the router
   output logic            start_o,
   output mem_req_t        req_o,
   input  wire logic       done_i,
   input  wire mem_resp_t  resp_i
);

   port_state_e  state_q;
   logic         start_q;
   mem_req_t     req_q;
   mem_resp_t    resp_q;

   always_ff @(posedge mig_clk) begin
      if (rst_i) begin
         state_q <= PORT_IDLE;
         start_q <= 1'b0;
      end else begin
         start_q <= 1'b0;   // single cycle pulse
         unique case (state_q)
            PORT_IDLE: begin
               if (req_i) begin
                  start_q <= 1'b1;
                  state_q <= PORT_BUSY;
               end
            end
            PORT_BUSY: begin
               // miss can answer in the start cycle itself
               if (done_i) begin
                  state_q <= PORT_ACK;
               end
            end
            PORT_ACK: begin
               if (!req_i) begin   // wait for master to let go
                  state_q <= PORT_IDLE;
               end
            end
            default: state_q <= PORT_IDLE;
         endcase
      end
   end

   // request and response payload
   always_ff @(posedge mig_clk) begin
      if (state_q == PORT_IDLE && req_i) begin
         req_q <= req_data_i;
      end
      if (state_q == PORT_BUSY && done_i) begin
         resp_q <= resp_i;   // held for the whole ack phase
      end
   end

   assign start_o = start_q;
   assign req_o   = req_q;
   assign ack_o   = (state_q == PORT_ACK);
   assign resp_o  = resp_q;

endmodule

`default_nettype wire

// ==== mem_sys.f ====
+incdir+common
+incdir+tests
common/mem_sys_pkg.sv
bram/boot_ram.sv
bram/bram_ctrl.sv
logic/addr_router.sv
logic/req_port.sv
logic/mem_sys_top.sv
tests/tb_mem_sys.sv

// ==== tests/mem_sys_tests.svh ====
// directed and random test tasks, included at the end of the testbench module

   task automatic write_and_track(input logic [`MEM_ADDR_W-1:0] addr,
                                  input logic [`MEM_DATA_W-1:0] data,
                                  input logic [`MEM_STRB_W-1:0] strb);
      mem_resp_t resp;
      do_access(MEM_WRITE, addr, data, strb, resp);
      expect_eq("resp_o.err", '0, resp.err);
      model_mem[line_of(addr)] = merge_bytes(model_mem[line_of(addr)], data, strb);
   endtask

   task automatic read_and_compare(input logic [`MEM_ADDR_W-1:0] addr);
      mem_resp_t resp;
      do_access(MEM_READ, addr, '0, '0, resp);
      expect_eq("resp_o.err", '0, resp.err);
      expect_eq("resp_o.rdata", model_mem[line_of(addr)], resp.rdata);
   endtask

   task automatic expect_miss(input mem_op_e op, input logic [`MEM_ADDR_W-1:0] addr);
      mem_resp_t resp;
      do_access(op, addr, 64'hffff_0000_ffff_0000, '1, resp);
      expect_eq("resp_o.err", 1, resp.err);
      expect_eq("resp_o.rdata", '0, resp.rdata);
   endtask

   // contents are undefined until written
   task automatic fill_ram();
      for (int i = 0; i < `BRAM_LINES; i++) begin
         write_and_track(i << `BRAM_LINE_OFFSET, {$random(seed), $random(seed)}, '1);
      end
   endtask

   task automatic handshake_rules();
      int         errs;
      mem_resp_t  held;
      errs = error_count;
      expect_eq("ack_o", '0, ack_o);   // straight out of reset
      req_data_i = '{op: MEM_WRITE, addr: 32'h28, wdata: 64'h0123_4567_89ab_cdef, strb: '1};
      repeat (3) begin
         @(posedge mig_clk);
         #DRIVE_DELAY;
         expect_eq("ack_o", '0, ack_o);
      end
      req_i = 1'b1;
      wait_ack(1'b1);
      held = resp_o;
      expect_eq("resp_o.err", '0, held.err);
      repeat (5) begin   // master holds req_i
         @(posedge mig_clk);
         #DRIVE_DELAY;
         expect_eq("ack_o", 1, ack_o);
         expect_eq("resp_o.rdata", held.rdata, resp_o.rdata);
         expect_eq("resp_o.err", held.err, resp_o.err);
      end
      req_i = 1'b0;
      wait_ack(1'b0);
      expect_eq("ack_o", '0, ack_o);
      model_mem[5] = 64'h0123_4567_89ab_cdef;
      report_test("handshake", errs);
   endtask

   task automatic full_line_write();
      int errs;
      errs = error_count;
      write_and_track(32'h0000_0100, 64'hdead_beef_cafe_f00d, '1);
      read_and_compare(32'h0000_0100);
      report_test("full write", errs);
   endtask

   task automatic partial_strobe_merge();
      int errs;
      errs = error_count;
      write_and_track(32'h0000_0238, 64'h1111_2222_3333_4444, 8'b1010_0101);
      read_and_compare(32'h0000_0238);
      write_and_track(32'h0000_0238, 64'h5555_6666_7777_8888, 8'b0000_0110);
      read_and_compare(32'h0000_0238);
      report_test("partial strobe", errs);
   endtask

   task automatic low_bits_alias();
      int errs;
      errs = error_count;
      write_and_track(32'h0000_0025, 64'hfeed_face_0bad_c0de, '1);
      read_and_compare(32'h0000_0020);
      read_and_compare(32'h0000_0027);
      expect_miss(MEM_WRITE, `BRAM_BASE - (`BRAM_MASK + 1));   // one region below base
      expect_miss(MEM_READ, `BRAM_BASE + `BRAM_MASK + 1);
      read_and_compare(`BRAM_BASE);
      report_test("line alias", errs);
   endtask

   task automatic decode_miss_isolation();
      int errs;
      errs = error_count;
      expect_miss(MEM_WRITE, 32'h4000_0040);
      expect_miss(MEM_READ, 32'h4000_0040);
      expect_miss(MEM_WRITE, 32'hffff_fff8);
      read_and_compare(32'h0000_0040);   // line 8 must be untouched
      read_and_compare(32'h0000_07f8);
      report_test("decode error", errs);
   endtask

   task automatic random_traffic();
      int                      errs;
      logic [`MEM_ADDR_W-1:0]  addr;
      logic [31:0]             r;
      errs = error_count;
      for (int n = 0; n < 40; n++) begin
         r    = $random(seed);
         addr = {21'b0, r[10:0]};   // any line, any byte offset
         if (r[16]) begin
            write_and_track(addr, {$random(seed), $random(seed)}, r[31:24]);
         end else begin
            read_and_compare(addr);
         end
      end
      report_test("random run", errs);
   endtask

// ==== tests/tb_mem_sys.sv ====
// testbench for the memory subsystem, runs directed and random accesses over the master port
`include "mem_sys_macros.svh"

`default_nettype none

module tb_mem_sys
   import mem_sys_pkg::*;
();

   localparam int HALF_PERIOD  = 10;
   localparam int DRIVE_DELAY  = 2;
   localparam int ACK_LIMIT    = 20;    // cycles allowed for one ack edge
   localparam int NUM_ACCESSES = 340;   // fill, directed and random accesses, rounded up
   localparam int TIMEOUT      = NUM_ACCESSES * 20 * 2 * HALF_PERIOD + 2000;

   logic       mig_clk;
   logic       rst_i;
   logic       req_i;
   mem_req_t   req_data_i;
   logic       ack_o;
   mem_resp_t  resp_o;

   logic [`MEM_DATA_W-1:0]  model_mem [0:`BRAM_LINES-1];
   int                      seed;
   int                      check_count;
   int                      error_count;

   mem_sys_top dut0 (
      .mig_clk    ( mig_clk    ),
      .rst_i      ( rst_i      ),
      .req_i      ( req_i      ),
      .req_data_i ( req_data_i ),
      .ack_o      ( ack_o      ),
      .resp_o     ( resp_o     )
   );

   always #HALF_PERIOD mig_clk = ~mig_clk;

   function automatic int line_of(input logic [`MEM_ADDR_W-1:0] addr);
      return (addr >> `BRAM_LINE_OFFSET) % `BRAM_LINES;
   endfunction

   // byte strobe rule of the RAM
   function automatic logic [`MEM_DATA_W-1:0] merge_bytes(
      input logic [`MEM_DATA_W-1:0] old_line,
      input logic [`MEM_DATA_W-1:0] new_line,
      input logic [`MEM_STRB_W-1:0] strb);
      logic [`MEM_DATA_W-1:0] line;
      line = old_line;
      for (int b = 0; b < `MEM_STRB_W; b++) begin
         if (strb[b]) line[b*8 +: 8] = new_line[b*8 +: 8];
      end
      return line;
   endfunction

   task automatic expect_eq(input string sig, input logic [`MEM_DATA_W-1:0] exp,
                            input logic [`MEM_DATA_W-1:0] got);
      check_count++;
      assert (got === exp)
      else begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, sig, exp, got);
         error_count++;
      end
   endtask

   // polls at the drive point, after outputs have settled
   task automatic wait_ack(input logic level);
      int cycles;
      cycles = 0;
      while (ack_o !== level && cycles < ACK_LIMIT) begin
         @(posedge mig_clk);
         #DRIVE_DELAY;
         cycles++;
      end
      assert (ack_o === level)
      else begin
         $display("at %0t: ack_o did not go to %0b within %0d cycles", $time, level, ACK_LIMIT);
         error_count++;
      end
   endtask

   // full four-phase handshake
   task automatic do_access(input mem_op_e op, input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [`MEM_DATA_W-1:0] wdata,
                            input logic [`MEM_STRB_W-1:0] strb, output mem_resp_t resp);
      req_data_i = '{op: op, addr: addr, wdata: wdata, strb: strb};
      req_i      = 1'b1;
      wait_ack(1'b1);
      resp  = resp_o;
      req_i = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("%-20s %s", name, (error_count == errs_before) ? "pass" : "fail");
   endtask

   initial begin
      #TIMEOUT;
      $display("watchdog expired after %0d time units, the run is stuck", TIMEOUT);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      mig_clk     = 1'b0;
      rst_i       = 1'b1;
      req_i       = 1'b0;
      req_data_i  = '0;
      seed        = 32'hc32b;
      check_count = 0;
      error_count = 0;
      repeat (3) @(posedge mig_clk);
      #DRIVE_DELAY;
      rst_i = 1'b0;
      handshake_rules();
      fill_ram();
      full_line_write();
      partial_strobe_merge();
      low_bits_alias();
      decode_miss_isolation();
      random_traffic();
      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   `include "mem_sys_tests.svh"

endmodule

`default_nettype wire
